/* list.f */
+incdir+.
telemetry_pkg.sv
change_logger.sv
hex_dump.sv
uart_link.sv
telemetry_core.sv
telemetry_assert.sv
tb_telemetry_core.sv

/* run.sh */
#!/bin/sh
# Builds and runs the telemetry testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f \
  --top-module tb_telemetry_core -o tb_telemetry_core > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

# Assertion errors must not stop the run before the summary line
./obj_dir/tb_telemetry_core +verilator+error+limit+1000 > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see sim.log"
  exit 1
fi

if grep -qx "test passed" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL, see sim.log"
exit 1

/* tb_telemetry_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "telemetry_config.svh"

module tb_telemetry_core;

  localparam int BIT_CYC = `TLM_BAUD_DIV;
  localparam int DEPTH   = `TLM_LOG_DEPTH;

  logic                         clock;
  logic                         usb_rst;
  logic                         enable_i;
  logic [`TLM_SIG_WIDTH-1:0]    sig_i;
  logic [`TLM_IGN_WIDTH-1:0]    ign_i;
  logic                         send_ni;
  logic                         uart_rx_i;
  logic                         uart_tx_o;
  logic                         dumping_o;
  logic [`TLM_LEVEL_WIDTH-1:0]  level_o;

  telemetry_pkg::log_word_t  model_q [$];  // Expected log words, oldest first
  logic [7:0]                rx_q [$];     // Bytes decoded from uart_tx_o
  logic [`TLM_SIG_WIDTH-1:0] last_sig = '0;
  logic [`TLM_IGN_WIDTH-1:0] frame_no = '0;

  int seed          = 91;
  int err_cnt       = 0;
  int frame_err_cnt = 0;
  int timeout_cnt   = 0;
  int assert_cnt    = 0;

  telemetry_core UUT (
    .clock    (clock),
    .usb_rst  (usb_rst),
    .enable_i (enable_i),
    .sig_i    (sig_i),
    .ign_i    (ign_i),
    .send_ni  (send_ni),
    .uart_rx_i(uart_rx_i),
    .uart_tx_o(uart_tx_o),
    .dumping_o(dumping_o),
    .level_o  (level_o)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // Serial decoder, mid-bit samples taken on the falling edge
  initial begin : tx_decoder
    logic [7:0] data;
    forever begin
      @(negedge clock);
      if (!usb_rst && uart_tx_o === 1'b0) begin
        repeat (BIT_CYC / 2) @(negedge clock);  // Middle of the start bit
        for (int i = 0; i < 8; i++) begin
          repeat (BIT_CYC) @(negedge clock);
          data[i] = uart_tx_o;
        end
        repeat (BIT_CYC) @(negedge clock);
        if (uart_tx_o !== 1'b1) begin
          frame_err_cnt++;
          $display("Stop bit missing on uart_tx_o at %0d ns", $time);
        end
        rx_q.push_back(data);
      end
    end
  end

  task automatic check(input logic ok, input string what);
    assert (ok) else begin
      err_cnt++;
      $display("[FAIL] %0d ns: %s", $time, what);
    end
  endtask

  function automatic logic [`TLM_SIG_WIDTH-1:0] rand_sig();
    logic [31:0] r;
    r = $random(seed);
    return r[`TLM_SIG_WIDTH-1:0];
  endfunction

  // One cycle of stimulus, mirrored into the model
  task automatic apply_sig(input logic [`TLM_SIG_WIDTH-1:0] value, input logic en);
    telemetry_pkg::log_word_t w;
    frame_no = frame_no + 1'b1;  // Ignored bits move every cycle
    @(posedge clock);
    enable_i <= en;
    sig_i    <= value;
    ign_i    <= frame_no;
    if (en && value != last_sig && model_q.size() < DEPTH) begin
      w.ign = frame_no;
      w.sig = value;
      model_q.push_back(w);
    end
    last_sig = value;
  endtask

  task automatic check_level();
    repeat (2) @(negedge clock);
    check(int'(level_o) == model_q.size(),
          $sformatf("level_o is %0d, model holds %0d", level_o, model_q.size()));
  endtask

  task automatic press_send();
    @(posedge clock);
    send_ni <= 1'b0;
    @(posedge clock);
    send_ni <= 1'b1;
  endtask

  // 8N1 frame on uart_rx_i, LSB first
  task automatic send_serial(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clock);
      uart_rx_i <= frame[i];
      repeat (BIT_CYC - 1) @(posedge clock);
    end
  endtask

  task automatic wait_dumping(input logic want, input int limit, input string what);
    int n;
    n = 0;
    do begin
      @(negedge clock);
      n++;
    end while (dumping_o !== want && n < limit);
    if (dumping_o !== want) begin
      timeout_cnt++;
      $display("Timed out after %0d cycles waiting for %s", n, what);
    end
  endtask

  task automatic wait_bytes(input int count, input int limit);
    int n;
    n = 0;
    while (rx_q.size() < count && n < limit) begin
      @(negedge clock);
      n++;
    end
    if (rx_q.size() < count) begin
      timeout_cnt++;
      $display("Timed out with %0d of %0d serial bytes received", rx_q.size(), count);
    end
  endtask

  // Triggers a dump and compares the serial text with the model
  task automatic dump_and_check(input logic by_uart);
    logic [7:0] exp_q [$];
    logic [31:0] w;
    string digits;
    digits = "0123456789ABCDEF";
    foreach (model_q[i]) begin
      w = model_q[i];
      for (int k = 7; k >= 0; k--) begin
        exp_q.push_back(digits[w[4*k +: 4]]);
      end
      exp_q.push_back(8'h0d);
      exp_q.push_back(8'h0a);
    end
    rx_q.delete();
    if (by_uart) begin
      send_serial(`TLM_DUMP_CMD);
    end else begin
      press_send();
    end
    wait_dumping(1'b1, 40, "dump start");
    wait_dumping(1'b0, (exp_q.size() + 2) * 10 * BIT_CYC + 100, "dump end");
    wait_bytes(exp_q.size(), 20 * BIT_CYC);
    repeat (12 * BIT_CYC) @(negedge clock);  // Room for a stray extra byte
    check(rx_q.size() == exp_q.size(),
          $sformatf("dump gave %0d bytes, expected %0d", rx_q.size(), exp_q.size()));
    foreach (exp_q[i]) begin
      if (i < rx_q.size()) begin
        check(rx_q[i] == exp_q[i],
              $sformatf("byte %0d is %02h, expected %02h", i, rx_q[i], exp_q[i]));
      end
    end
    model_q.delete();
    check(level_o == '0, $sformatf("level_o is %0d after dump", level_o));
  endtask

  initial begin : stimulus
    usb_rst   = 1'b1;
    enable_i  = 1'b0;
    sig_i     = '0;
    ign_i     = '0;
    send_ni   = 1'b1;
    uart_rx_i = 1'b1;
    repeat (8) @(posedge clock);
    usb_rst <= 1'b0;

    repeat (20) begin
      @(negedge clock);
      check(uart_tx_o === 1'b1 && dumping_o === 1'b0 && level_o === '0,
            "outputs not idle after reset");
    end

    // Only changes are logged, the ignored bits never trigger
    apply_sig(20'h00001, 1'b1);
    repeat (4) apply_sig(20'h00001, 1'b1);
    check_level();
    for (int i = 0; i < 5; i++) apply_sig(rand_sig(), 1'b1);
    check_level();
    for (int i = 0; i < 4; i++) apply_sig(rand_sig(), 1'b0);
    apply_sig(last_sig, 1'b1);  // Same value as the cycle before enable
    check_level();

    dump_and_check(1'b0);

    // Any other received byte leaves the log alone
    for (int i = 0; i < 4; i++) apply_sig(rand_sig(), 1'b1);
    check_level();
    send_serial(8'h62);
    repeat (4 * BIT_CYC) begin
      @(negedge clock);
      check(!dumping_o, "a byte other than the dump command started a dump");
    end
    check_level();
    dump_and_check(1'b1);

    // Overflow keeps the oldest words
    for (int i = 0; i < DEPTH + 4; i++) begin
      apply_sig(20'(i * 20'h01357 + 20'h00abc), 1'b1);
    end
    check_level();
    dump_and_check(1'b0);

    dump_and_check(1'b0);  // Empty FIFO

    repeat (10) @(posedge clock);
    assert_cnt = UUT.u_assert.fail_reset + UUT.u_assert.fail_level +
                 UUT.u_assert.fail_log + UUT.u_assert.fail_byte +
                 UUT.u_assert.fail_start + UUT.u_assert.fail_last;
    $display("Errors: %0d checks, %0d serial, %0d timeouts, %0d assertions",
             err_cnt, frame_err_cnt, timeout_cnt, assert_cnt);
    if (err_cnt + frame_err_cnt + timeout_cnt + assert_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* telemetry_assert.sv */
`timescale 1ns/1ps
`default_nettype none
`include "telemetry_config.svh"

module telemetry_assert (
  input wire                               clock,
  input wire                               usb_rst,
  input wire                               uart_tx_i,
  input wire                               dumping_i,
  input wire [`TLM_LEVEL_WIDTH-1:0]        level_i,
  input wire telemetry_pkg::log_word_t     log_word_i,
  input wire                               log_valid_i,
  input wire                               log_ready_i,
  input wire telemetry_pkg::byte_stream_t  tx_byte_i,
  input wire                               tx_ready_i,
  input wire                               start_i
);

  int fail_reset = 0;
  int fail_level = 0;
  int fail_log   = 0;
  int fail_byte  = 0;
  int fail_start = 0;
  int fail_last  = 0;

  // Line idle and no dump right after reset
  reset_idle: assert property (@(posedge clock) usb_rst |=> uart_tx_i && !dumping_i)
    else begin
      fail_reset++;
      $error("uart_tx not high or dump running after reset");
    end

  level_bound: assert property (@(posedge clock) disable iff (usb_rst)
    int'(level_i) <= `TLM_LOG_DEPTH)
    else begin
      fail_level++;
      $error("FIFO level above depth");
    end

  log_hold: assert property (@(posedge clock) disable iff (usb_rst)
    log_valid_i && !log_ready_i |=> log_valid_i && $stable(log_word_i))
    else begin
      fail_log++;
      $error("log word changed while waiting for ready");
    end

  byte_hold: assert property (@(posedge clock) disable iff (usb_rst)
    tx_byte_i.valid && !tx_ready_i |=> tx_byte_i.valid && $stable(tx_byte_i))
    else begin
      fail_byte++;
      $error("tx byte changed while waiting for ready");
    end

  // A dump begins exactly one cycle after each start pulse, and at no other time
  start_accept: assert property (@(posedge clock) disable iff (usb_rst)
    $rose(dumping_i) == $past(start_i))
    else begin
      fail_start++;
      $error("dump start out of step with the start pulse");
    end

  // An accepted last byte ends the dump, any other LF lets it go on
  last_lf: assert property (@(posedge clock) disable iff (usb_rst)
    tx_byte_i.valid && tx_ready_i && (tx_byte_i.data == 8'h0a || tx_byte_i.last) |=>
      dumping_i == !$past(tx_byte_i.last))
    else begin
      fail_last++;
      $error("last flag disagrees with the end of the dump");
    end

endmodule

bind telemetry_core telemetry_assert u_assert (
  .clock      (clock),
  .usb_rst    (usb_rst),
  .uart_tx_i  (uart_tx_o),
  .dumping_i  (dumping_o),
  .level_i    (level_o),
  .log_word_i (log_word),
  .log_valid_i(log_valid),
  .log_ready_i(log_ready),
  .tx_byte_i  (tx_byte),
  .tx_ready_i (tx_ready),
  .start_i    (dump_start)
);

`default_nettype wire

/* telemetry_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "telemetry_config.svh"

module telemetry_core (
  input  wire                          clock,
  input  wire                          usb_rst,
  input  wire                          enable_i,
  input  wire  [`TLM_SIG_WIDTH-1:0]    sig_i,
  input  wire  [`TLM_IGN_WIDTH-1:0]    ign_i,
  input  wire                          send_ni,
  input  wire                          uart_rx_i,
  output logic                         uart_tx_o,
  output logic                         dumping_o,
  output logic [`TLM_LEVEL_WIDTH-1:0]  level_o
);

  telemetry_pkg::log_word_t    log_word;
  telemetry_pkg::byte_stream_t tx_byte;
  telemetry_pkg::byte_stream_t rx_byte;

  logic log_valid;
  logic log_ready;
  logic tx_ready;
  logic send_q;
  logic rx_cmd;
  logic dump_start;

  // Button level, sampled every cycle
  always_ff @(posedge clock) begin
    if (usb_rst) begin
      send_q <= 1'b1;
    end else begin
      send_q <= send_ni;
    end
  end

  assign rx_cmd     = rx_byte.valid && (rx_byte.data == `TLM_DUMP_CMD);
  assign dump_start = !dumping_o && (!send_q || rx_cmd);  // Ignored mid-dump

  change_logger u_logger (
    .clock    (clock),
    .usb_rst  (usb_rst),
    .enable_i (enable_i),
    .sig_i    (sig_i),
    .ign_i    (ign_i),
    .level_o  (level_o),
    .m_word_o (log_word),
    .m_valid_o(log_valid),
    .m_ready_i(log_ready)
  );

  hex_dump u_dump (
    .clock    (clock),
    .usb_rst  (usb_rst),
    .start_i  (dump_start),
    .dumping_o(dumping_o),
    .s_word_i (log_word),
    .s_valid_i(log_valid),
    .s_ready_o(log_ready),
    .m_byte_o (tx_byte),
    .m_ready_i(tx_ready)
  );

  uart_link u_uart (
    .clock    (clock),
    .usb_rst  (usb_rst),
    .s_byte_i (tx_byte),
    .s_ready_o(tx_ready),
    .m_byte_o (rx_byte),
    .uart_rx_i(uart_rx_i),
    .uart_tx_o(uart_tx_o)
  );

endmodule

`default_nettype wire

/* uart_link.sv */
`timescale 1ns/1ps
`default_nettype none
`include "telemetry_config.svh"

module uart_link (
  input  wire                               clock,
  input  wire                               usb_rst,
  input  wire telemetry_pkg::byte_stream_t  s_byte_i,
  output logic                              s_ready_o,
  output telemetry_pkg::byte_stream_t       m_byte_o,
  input  wire                               uart_rx_i,
  output logic                              uart_tx_o
);

  localparam int CW = $clog2(`TLM_BAUD_DIV);

  telemetry_pkg::uart_state_e tx_state;
  telemetry_pkg::uart_state_e rx_state;

  logic [CW-1:0] tx_cnt;
  logic [2:0]    tx_bit;
  logic [7:0]    tx_shift;
  logic          tx_q;
  logic          tx_tick;

  logic          rx_s1;
  logic          rx_s2;
  logic [CW-1:0] rx_cnt;
  logic [2:0]    rx_bit;
  logic [7:0]    rx_shift;
  logic          rx_valid_q;

  assign tx_tick   = (tx_cnt == CW'(`TLM_BAUD_DIV - 1));
  assign s_ready_o = (tx_state == telemetry_pkg::UART_IDLE);
  assign uart_tx_o = tx_q;

  // Transmitter, 8N1 with the LSB first
  always_ff @(posedge clock) begin
    if (usb_rst) begin
      tx_state <= telemetry_pkg::UART_IDLE;
      tx_cnt   <= '0;
      tx_bit   <= '0;
      tx_q     <= 1'b1;
    end else begin
      tx_cnt <= (tx_state == telemetry_pkg::UART_IDLE || tx_tick) ? '0 : tx_cnt + 1'b1;
      case (tx_state)
        telemetry_pkg::UART_IDLE: begin
          if (s_byte_i.valid) begin
            tx_shift <= s_byte_i.data;
            tx_q     <= 1'b0;  // Start bit
            tx_state <= telemetry_pkg::UART_START;
          end
        end
        telemetry_pkg::UART_START: begin
          if (tx_tick) begin
            tx_q     <= tx_shift[0];
            tx_bit   <= '0;
            tx_state <= telemetry_pkg::UART_DATA;
          end
        end
        telemetry_pkg::UART_DATA: begin
          if (tx_tick) begin
            if (tx_bit == 3'd7) begin
              tx_q     <= 1'b1;  // Stop bit
              tx_state <= telemetry_pkg::UART_STOP;
            end else begin
              tx_shift <= {1'b0, tx_shift[7:1]};
              tx_q     <= tx_shift[1];
              tx_bit   <= tx_bit + 1'b1;
            end
          end
        end
        telemetry_pkg::UART_STOP: begin
          if (tx_tick) begin
            tx_state <= telemetry_pkg::UART_IDLE;
          end
        end
        default: tx_state <= telemetry_pkg::UART_IDLE;
      endcase
    end
  end

  // Receiver, counts half a bit from the start edge and then whole bits
  always_ff @(posedge clock) begin
    if (usb_rst) begin
      rx_s1      <= 1'b1;
      rx_s2      <= 1'b1;
      rx_state   <= telemetry_pkg::UART_IDLE;
      rx_cnt     <= '0;
      rx_bit     <= '0;
      rx_valid_q <= 1'b0;
    end else begin
      rx_s1      <= uart_rx_i;
      rx_s2      <= rx_s1;
      rx_valid_q <= 1'b0;
      rx_cnt     <= rx_cnt + 1'b1;
      case (rx_state)
        telemetry_pkg::UART_IDLE: begin
          rx_cnt <= '0;
          if (!rx_s2) begin
            rx_state <= telemetry_pkg::UART_START;
          end
        end
        telemetry_pkg::UART_START: begin
          if (rx_cnt == CW'(`TLM_BAUD_DIV / 2 - 1)) begin
            rx_cnt   <= '0;
            rx_bit   <= '0;
            // A short low pulse is a glitch, not a start bit
            rx_state <= rx_s2 ? telemetry_pkg::UART_IDLE : telemetry_pkg::UART_DATA;
          end
        end
        telemetry_pkg::UART_DATA: begin
          if (rx_cnt == CW'(`TLM_BAUD_DIV - 1)) begin
            rx_cnt   <= '0;
            rx_shift <= {rx_s2, rx_shift[7:1]};
            rx_bit   <= rx_bit + 1'b1;
            if (rx_bit == 3'd7) begin
              rx_state <= telemetry_pkg::UART_STOP;
            end
          end
        end
        telemetry_pkg::UART_STOP: begin
          if (rx_cnt == CW'(`TLM_BAUD_DIV - 1)) begin
            rx_valid_q <= rx_s2;  // Framing errors are silently dropped
            rx_state   <= telemetry_pkg::UART_IDLE;
          end
        end
        default: rx_state <= telemetry_pkg::UART_IDLE;
      endcase
    end
  end

  assign m_byte_o.valid = rx_valid_q;
  assign m_byte_o.last  = 1'b1;  // Each received byte stands alone
  assign m_byte_o.data  = rx_shift;

endmodule

`default_nettype wire

/* hex_dump.sv */
`timescale 1ns/1ps
`default_nettype none

module hex_dump (
  input  wire                            clock,
  input  wire                            usb_rst,
  input  wire                            start_i,
  output logic                           dumping_o,
  input  wire telemetry_pkg::log_word_t  s_word_i,
  input  wire                            s_valid_i,
  output logic                           s_ready_o,
  output telemetry_pkg::byte_stream_t    m_byte_o,
  input  wire                            m_ready_i
);

  localparam int WW      = $bits(telemetry_pkg::log_word_t);
  localparam int NIBBLES = WW / 4;
  localparam int NW      = $clog2(NIBBLES);

  telemetry_pkg::dump_state_e state;

  logic [WW-1:0] word_q;   // Shifts left one nibble per character
  logic [NW-1:0] nib_cnt;
  logic          last_q;   // No word waiting when the LF was queued
  logic          byte_acc;

  function automatic logic [7:0] hex_char(input logic [3:0] nib);
    logic [7:0] chr;
    if (nib < 4'd10) begin
      chr = 8'h30 + {4'h0, nib};
    end else begin
      chr = 8'h37 + {4'h0, nib};  // Upper case letters
    end
    return chr;
  endfunction

  assign byte_acc = m_byte_o.valid && m_ready_i;

  always_ff @(posedge clock) begin
    if (usb_rst) begin
      state   <= telemetry_pkg::DUMP_IDLE;
      nib_cnt <= '0;
      last_q  <= 1'b0;
    end else begin
      case (state)
        telemetry_pkg::DUMP_IDLE: begin
          if (start_i) begin
            state <= telemetry_pkg::DUMP_FETCH;
          end
        end
        telemetry_pkg::DUMP_FETCH: begin
          if (s_valid_i) begin
            word_q  <= s_word_i;
            nib_cnt <= '0;
            state   <= telemetry_pkg::DUMP_NIBBLE;
          end else begin
            state <= telemetry_pkg::DUMP_IDLE;  // Empty FIFO ends the dump at once
          end
        end
        telemetry_pkg::DUMP_NIBBLE: begin
          if (byte_acc) begin
            word_q <= {word_q[WW-5:0], 4'h0};
            if (nib_cnt == NW'(NIBBLES - 1)) begin
              state <= telemetry_pkg::DUMP_CR;
            end else begin
              nib_cnt <= nib_cnt + 1'b1;
            end
          end
        end
        telemetry_pkg::DUMP_CR: begin
          if (byte_acc) begin
            last_q <= !s_valid_i;  // Frozen so the LF byte stays stable
            state  <= telemetry_pkg::DUMP_LF;
          end
        end
        telemetry_pkg::DUMP_LF: begin
          if (byte_acc) begin
            state <= last_q ? telemetry_pkg::DUMP_IDLE : telemetry_pkg::DUMP_FETCH;
          end
        end
        default: state <= telemetry_pkg::DUMP_IDLE;
      endcase
    end
  end

  always_comb begin
    m_byte_o = '0;
    case (state)
      telemetry_pkg::DUMP_NIBBLE: begin
        m_byte_o.valid = 1'b1;
        m_byte_o.data  = hex_char(word_q[WW-1 -: 4]);
      end
      telemetry_pkg::DUMP_CR: begin
        m_byte_o.valid = 1'b1;
        m_byte_o.data  = 8'h0d;
      end
      telemetry_pkg::DUMP_LF: begin
        m_byte_o.valid = 1'b1;
        m_byte_o.last  = last_q;
        m_byte_o.data  = 8'h0a;
      end
      default: m_byte_o = '0;
    endcase
  end

  assign s_ready_o = (state == telemetry_pkg::DUMP_FETCH);
  assign dumping_o = (state != telemetry_pkg::DUMP_IDLE);

endmodule

`default_nettype wire

/* change_logger.sv */
`timescale 1ns/1ps
`default_nettype none
`include "telemetry_config.svh"

module change_logger (
  input  wire                            clock,
  input  wire                            usb_rst,
  input  wire                            enable_i,
  input  wire  [`TLM_SIG_WIDTH-1:0]      sig_i,
  input  wire  [`TLM_IGN_WIDTH-1:0]      ign_i,
  output logic [`TLM_LEVEL_WIDTH-1:0]    level_o,
  output telemetry_pkg::log_word_t       m_word_o,
  output logic                           m_valid_o,
  input  wire                            m_ready_i
);

  localparam int AW = $clog2(`TLM_LOG_DEPTH);

  telemetry_pkg::log_word_t mem [`TLM_LOG_DEPTH];

  logic [`TLM_SIG_WIDTH-1:0]   sig_q;
  logic [AW-1:0]               wr_ptr;
  logic [AW-1:0]               rd_ptr;
  logic [`TLM_LEVEL_WIDTH-1:0] level_q;
  logic                        full;
  logic                        wr_en;
  logic                        rd_en;

  // Circular pointer step, also correct for depths that are not a power of two
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
    logic [AW-1:0] nxt;
    if (ptr == AW'(`TLM_LOG_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign full  = (level_q == `TLM_LEVEL_WIDTH'(`TLM_LOG_DEPTH));
  assign wr_en = enable_i && (sig_i != sig_q) && !full;  // Full FIFO drops the capture
  assign rd_en = m_valid_o && m_ready_i;

  // Previous value tracks every cycle, even while disabled
  always_ff @(posedge clock) begin
    if (usb_rst) begin
      sig_q <= '0;
    end else begin
      sig_q <= sig_i;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      mem[wr_ptr] <= '{ign: ign_i, sig: sig_i};
    end
  end

  always_ff @(posedge clock) begin
    if (usb_rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      level_q <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({wr_en, rd_en})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;  // Idle, or write and read together
      endcase
    end
  end

  // Head word stays put until taken, writes never land on it while not empty
  assign m_word_o  = mem[rd_ptr];
  assign m_valid_o = (level_q != '0);
  assign level_o   = level_q;

endmodule

`default_nettype wire

/* telemetry_pkg.sv */
`default_nettype none
`include "telemetry_config.svh"

package telemetry_pkg;

  // Captured word, printed most significant nibble first
  typedef struct packed {
    logic [`TLM_IGN_WIDTH-1:0] ign;
    logic [`TLM_SIG_WIDTH-1:0] sig;
  } log_word_t;

  typedef struct packed {
    logic       valid;
    logic       last;  // Final byte of a dump
    logic [7:0] data;
  } byte_stream_t;

  typedef enum logic [2:0] {
    DUMP_IDLE,
    DUMP_FETCH,
    DUMP_NIBBLE,
    DUMP_CR,
    DUMP_LF
  } dump_state_e;

  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

endpackage

`default_nettype wire

/* telemetry_config.svh */
`ifndef TELEMETRY_CONFIG_SVH
`define TELEMETRY_CONFIG_SVH

// Watched status bits, any change here triggers a capture
`define TLM_SIG_WIDTH 20

// Frame counter and error flag, stored but never compared
`define TLM_IGN_WIDTH 12

`define TLM_LOG_DEPTH 16  // Log words held in the FIFO
`define TLM_LEVEL_WIDTH ($clog2(`TLM_LOG_DEPTH) + 1)

// Clock cycles per UART bit, small for simulation
`define TLM_BAUD_DIV 16

`define TLM_DUMP_CMD 8'h61  // ASCII "a"

`endif
